// ==== compile.f ====
+incdir+source
+incdir+verif
source/boot_pkg.sv
source/instr_mem.sv
source/program_loader.sv
source/fetch_decode.sv
source/boot_top.sv
verif/boot_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the boot front end testbench with verilator
# run from anywhere, paths are relative to the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

# compile testbench and rtl into one binary
verilator --binary --timing -f compile.f --top-module boot_tb -o boot_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# simulation output goes to the log
./obj_dir/boot_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log text
if grep -q "all tests passed" sim.log; then
    exit 0
else
    echo "pass line not found in sim.log"
    exit 1
fi

// ==== source/boot_pkg.sv ====
`default_nettype none

package boot_pkg;

    // image size and memory geometry
    localparam int prog_len = 97;
    localparam int addr_w = 7;
    localparam int word_w = 32;
    // index of the final image word
    localparam logic [addr_w-1:0] last_addr = addr_w'(prog_len - 1);

    // base opcodes of rv32i
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_system = 7'b1110011;
    // f extension, only classified
    localparam logic [6:0] opc_load_fp = 7'b0000111;
    localparam logic [6:0] opc_store_fp = 7'b0100111;
    localparam logic [6:0] opc_op_fp = 7'b1010011;
    localparam logic [6:0] opc_fmadd = 7'b1000011;
    localparam logic [6:0] opc_fmsub = 7'b1000111;
    localparam logic [6:0] opc_fnmsub = 7'b1001011;
    localparam logic [6:0] opc_fnmadd = 7'b1001111;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // immediate layout, loads, jalr, system
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_view_t;

    // store layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // one fetched word, read through whichever layout the opcode calls for
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
    } instr_word_u;

    typedef enum logic [3:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        jal,
        jalr,
        lui,
        auipc,
        fp,
        system,
        other
    } op_class_e;

    // loader write port
    typedef struct packed {
        logic en;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;
    } mem_wr_t;

    // decoded record out of fetch
    typedef struct packed {
        logic [addr_w-1:0] idx;
        op_class_e cls;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [word_w-1:0] imm;
    } dec_instr_t;

endpackage

`default_nettype wire

// ==== source/boot_program.svh ====
// boot image, entry index equals word address
// pulled into module scope by the loader and the testbench model
// main sets up a frame, loads two float constants, calls two helpers
// second helper is a float loop, third prints bits of a word
localparam logic [31:0] boot_image [0:boot_pkg::prog_len-1] = '{
    // main, frame setup
    32'hfe010113, 32'h00112e23,
    32'h00812c23, 32'h02010413,
    // float constants from data page
    32'h000107b7, 32'h0007a787,
    32'hfef42627, 32'h000107b7,
    32'h0047a787, 32'h20f785d3,
    // first call, result stored back
    32'hfec42507, 32'h028000ef,
    32'hfea42427, 32'hfe842507,
    32'h0c4000ef, 32'h00000793,
    // main epilogue
    32'h00078513, 32'h01c12083,
    32'h01812403, 32'h02010113,
    // ecall style exit word
    32'h000fd073,
    // float helper, prologue and spills
    32'hfd010113, 32'h02112623,
    32'h02812423, 32'h03010413,
    32'hfca42e27, 32'hfcb42c27,
    32'hfdc42707, 32'h000107b7,
    32'h0007a787, 32'h18f777d3,
    32'hfef42627, 32'h0280006f,
    // loop body, fdiv/fadd/fmul chain
    32'hfdc42707, 32'hfec42787,
    32'h18f77753, 32'hfec42787,
    32'h00f77753, 32'h000107b7,
    32'h0087a787, 32'h10f777d3,
    32'hfef42627, 32'hfec42787,
    32'h10f7f753, 32'hfdc42787,
    32'h08f777d3, 32'hfd842707,
    // compare and back branch
    32'ha0f717d3, 32'hfc0792e3,
    32'hfec42787, 32'h10f7f753,
    32'hfdc42787, 32'h08f77753,
    32'hfd842787, 32'h20f797d3,
    32'ha0f717d3, 32'hfa0792e3,
    // return value and epilogue
    32'hfec42787, 32'h20f78553,
    32'h02c12083, 32'h02812403,
    32'h03010113, 32'h00008067,
    // bit printer, prologue
    32'hfd010113, 32'h02112623,
    32'h02812423, 32'h03010413,
    32'hfca42e27, 32'hfdc40793,
    32'hfef42423, 32'hfe842783,
    32'h0007a783, 32'hfef42223,
    // bit index starts at 31
    32'h01f00793, 32'hfef42623,
    32'h0380006f, 32'hfec42783,
    // shift, mask, pick '0' or '1'
    32'hfe442703, 32'h00f757b3,
    32'h0017f793, 32'h00078663,
    32'h03100793, 32'h0080006f,
    32'h03000793, 32'h00078513,
    32'h034000ef, 32'hfec42783,
    // decrement and loop while >= 0
    32'hfff78793, 32'hfef42623,
    32'hfec42783, 32'hfc07d4e3,
    // newline call and start of epilogue
    32'h00a00513, 32'h018000ef,
    32'h00000013, 32'h02c12083,
    32'h02812403, 32'h03010113
};

// ==== source/boot_top.sv ====
`default_nettype none

module boot_top (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic hold,
    output logic loading,
    output logic load_done,
    output logic dec_valid,
    output boot_pkg::dec_instr_t dec,
    output logic run_done
);

    // loader write port
    boot_pkg::mem_wr_t wr;
    // fetch read port
    logic rd_en;
    logic [boot_pkg::addr_w-1:0] rd_addr;
    logic [boot_pkg::word_w-1:0] rd_data;

    // fills memory after start
    program_loader u_loader (
        .clk(clk),
        .reset(reset),
        .start(start),
        .wr(wr),
        .loading(loading),
        .load_done(load_done)
    );

    instr_mem u_mem (
        .clk(clk),
        .wr(wr),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // starts reading on load_done
    fetch_decode u_fetch (
        .clk(clk),
        .reset(reset),
        .start(start),
        .load_done(load_done),
        .hold(hold),
        .rd_data(rd_data),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .dec_valid(dec_valid),
        .dec(dec),
        .run_done(run_done)
    );

endmodule

`default_nettype wire

// ==== source/fetch_decode.sv ====
`default_nettype none

module fetch_decode (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    input wire logic load_done,
    input wire logic hold,
    input wire logic [boot_pkg::word_w-1:0] rd_data,
    output logic rd_en,
    output logic [boot_pkg::addr_w-1:0] rd_addr,
    output logic dec_valid,
    output boot_pkg::dec_instr_t dec,
    output logic run_done
);

    // pc and issue state
    logic fetching;
    logic [boot_pkg::addr_w-1:0] pc;
    // shadow of the read in flight in the memory register
    logic s1_valid;
    logic [boot_pkg::addr_w-1:0] s1_idx;
    // decode path
    boot_pkg::instr_word_u iw;
    boot_pkg::op_class_e cls;
    boot_pkg::dec_instr_t rec;

    // no issue while held
    assign rd_en = fetching && !hold;
    assign rd_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetching <= 1'b0;
            pc <= '0;
            s1_valid <= 1'b0;
            dec_valid <= 1'b0;
            run_done <= 1'b0;
        end else if (start) begin
            // new load coming, drop everything
            fetching <= 1'b0;
            s1_valid <= 1'b0;
            dec_valid <= 1'b0;
            run_done <= 1'b0;
        end else begin
            if (load_done) begin
                fetching <= 1'b1;
                pc <= '0;
            end else if (rd_en) begin
                pc <= pc + 1'b1;
                // stop after the final address
                if (pc == boot_pkg::last_addr) begin
                    fetching <= 1'b0;
                end
            end
            // stages advance only when not held
            if (!hold) begin
                s1_valid <= rd_en;
                dec_valid <= s1_valid;
            end else begin
                dec_valid <= 1'b0;
            end
            // sticky until next start
            if (dec_valid && (dec.idx == boot_pkg::last_addr)) begin
                run_done <= 1'b1;
            end
        end
    end

    // payload side, follows the valid bits above
    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_idx <= pc;
        end
        if (s1_valid && !hold) begin
            dec <= rec;
        end
    end

    // memory word seen through the union views
    assign iw = rd_data;

    // class from opcode
    always_comb begin
        case (iw.r_view.opcode)
            boot_pkg::opc_op: cls = boot_pkg::alu_reg;
            boot_pkg::opc_op_imm: cls = boot_pkg::alu_imm;
            boot_pkg::opc_load: cls = boot_pkg::load;
            boot_pkg::opc_store: cls = boot_pkg::store;
            boot_pkg::opc_branch: cls = boot_pkg::branch;
            boot_pkg::opc_jal: cls = boot_pkg::jal;
            boot_pkg::opc_jalr: cls = boot_pkg::jalr;
            boot_pkg::opc_lui: cls = boot_pkg::lui;
            boot_pkg::opc_auipc: cls = boot_pkg::auipc;
            boot_pkg::opc_system: cls = boot_pkg::system;
            boot_pkg::opc_load_fp,
            boot_pkg::opc_store_fp,
            boot_pkg::opc_op_fp,
            boot_pkg::opc_fmadd,
            boot_pkg::opc_fmsub,
            boot_pkg::opc_fnmsub,
            boot_pkg::opc_fnmadd: cls = boot_pkg::fp;
            default: cls = boot_pkg::other;
        endcase
    end

    // register fields and immediate per class
    always_comb begin
        rec.idx = s1_idx;
        rec.cls = cls;
        // no destination for store, branch, system
        if (cls inside {boot_pkg::store, boot_pkg::branch, boot_pkg::system}) begin
            rec.rd = '0;
        end else begin
            rec.rd = iw.r_view.rd;
        end
        // rs1 bits are immediate for upper-immediate and jal
        if (cls inside {boot_pkg::lui, boot_pkg::auipc, boot_pkg::jal}) begin
            rec.rs1 = '0;
        end else begin
            rec.rs1 = iw.r_view.rs1;
        end
        if (cls inside {boot_pkg::alu_reg, boot_pkg::store, boot_pkg::branch, boot_pkg::fp}) begin
            rec.rs2 = iw.r_view.rs2;
        end else begin
            rec.rs2 = '0;
        end
        case (cls)
            boot_pkg::alu_imm, boot_pkg::load, boot_pkg::jalr, boot_pkg::system:
                rec.imm = {{20{iw.i_view.imm12[11]}}, iw.i_view.imm12};
            boot_pkg::store:
                rec.imm = {{20{iw.s_view.imm_hi[6]}}, iw.s_view.imm_hi, iw.s_view.imm_lo};
            // upper 20 bits, low 12 zero
            boot_pkg::lui, boot_pkg::auipc:
                rec.imm = {iw[31:12], 12'b0};
            default:
                rec.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/instr_mem.sv ====
`default_nettype none

module instr_mem (
    input wire logic clk,
    input wire boot_pkg::mem_wr_t wr,
    input wire logic rd_en,
    input wire logic [boot_pkg::addr_w-1:0] rd_addr,
    output logic [boot_pkg::word_w-1:0] rd_data
);

    // one entry per image word
    logic [boot_pkg::word_w-1:0] mem [0:boot_pkg::prog_len-1];

    // write port, loader side
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, data one cycle after rd_en
    // output keeps last word while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/program_loader.sv ====
`default_nettype none

module program_loader (
    input wire logic clk,
    input wire logic reset,
    input wire logic start,
    output boot_pkg::mem_wr_t wr,
    output logic loading,
    output logic load_done
);

    // image constant
    `include "boot_program.svh"

    // word counter, also the write address
    logic [boot_pkg::addr_w-1:0] word_cnt;
    logic last_word;

    assign last_word = (word_cnt == boot_pkg::last_addr);

    // loading doubles as the address-select level for the memory
    always_ff @(posedge clk) begin
        if (reset) begin
            loading <= 1'b0;
            load_done <= 1'b0;
            word_cnt <= '0;
        end else begin
            // single cycle pulse by default
            load_done <= 1'b0;
            if (loading) begin
                if (last_word) begin
                    // last word went out this cycle
                    loading <= 1'b0;
                    load_done <= 1'b1;
                    word_cnt <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (start) begin
                // start while loading falls through to the branch above
                loading <= 1'b1;
                word_cnt <= '0;
            end
        end
    end

    // one word per loading cycle
    // word i lands on the edge that closes cycle i+1 after start
    assign wr.en = loading;
    assign wr.addr = word_cnt;
    assign wr.data = boot_image[word_cnt];

endmodule

`default_nettype wire

// ==== verif/boot_tb_model.svh ====
// image words, same list the loader writes
`include "boot_program.svh"

// expected record per image word
boot_pkg::dec_instr_t exp_recs [0:boot_pkg::prog_len-1];

// major opcode to class
function automatic boot_pkg::op_class_e class_of(logic [6:0] op);
    case (op)
        7'h33: return boot_pkg::alu_reg;
        7'h13: return boot_pkg::alu_imm;
        7'h03: return boot_pkg::load;
        7'h23: return boot_pkg::store;
        7'h63: return boot_pkg::branch;
        7'h6f: return boot_pkg::jal;
        7'h67: return boot_pkg::jalr;
        7'h37: return boot_pkg::lui;
        7'h17: return boot_pkg::auipc;
        7'h73: return boot_pkg::system;
        // flw, fsw, op-fp and the fused multiply-add group
        7'h07, 7'h27, 7'h53, 7'h43, 7'h47, 7'h4b, 7'h4f: return boot_pkg::fp;
        default: return boot_pkg::other;
    endcase
endfunction

// reference decode straight from bit positions
function automatic boot_pkg::dec_instr_t model_decode(
    logic [boot_pkg::addr_w-1:0] idx,
    logic [31:0] w
);
    boot_pkg::dec_instr_t r;
    boot_pkg::op_class_e c;
    c = class_of(w[6:0]);
    r.idx = idx;
    r.cls = c;
    // no destination field for store, branch, system
    if (c == boot_pkg::store || c == boot_pkg::branch || c == boot_pkg::system) begin
        r.rd = 5'd0;
    end else begin
        r.rd = w[11:7];
    end
    if (c == boot_pkg::lui || c == boot_pkg::auipc || c == boot_pkg::jal) begin
        r.rs1 = 5'd0;
    end else begin
        r.rs1 = w[19:15];
    end
    if (c == boot_pkg::alu_reg || c == boot_pkg::store || c == boot_pkg::branch
            || c == boot_pkg::fp) begin
        r.rs2 = w[24:20];
    end else begin
        r.rs2 = 5'd0;
    end
    case (c)
        boot_pkg::alu_imm, boot_pkg::load, boot_pkg::jalr, boot_pkg::system:
            r.imm = {{20{w[31]}}, w[31:20]};
        // store immediate is split across two fields
        boot_pkg::store:
            r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        boot_pkg::lui, boot_pkg::auipc:
            r.imm = {w[31:12], 12'h000};
        default:
            r.imm = 32'h0;
    endcase
    return r;
endfunction

// fill the expected list once before stimulus
task automatic build_expected();
    for (int i = 0; i < boot_pkg::prog_len; i++) begin
        exp_recs[i] = model_decode(i[boot_pkg::addr_w-1:0], boot_image[i]);
    end
endtask

// ==== verif/boot_tb.sv ====
`default_nettype none

module boot_tb;

    logic clk;
    logic reset;
    logic start;
    logic hold;
    logic loading;
    logic load_done;
    logic dec_valid;
    boot_pkg::dec_instr_t dec;
    logic run_done;

    // hold as the DUT sampled it on the last rising edge
    logic hold_prev;
    // first run records, replayed against run two
    boot_pkg::dec_instr_t first_run [0:boot_pkg::prog_len-1];

    `include "boot_tb_model.svh"

    boot_top UUT (
        .clk(clk),
        .reset(reset),
        .start(start),
        .hold(hold),
        .loading(loading),
        .load_done(load_done),
        .dec_valid(dec_valid),
        .dec(dec),
        .run_done(run_done)
    );

    // period 40
    always #20 clk = ~clk;

    task automatic fail_now(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_record(string name, boot_pkg::dec_instr_t got,
                                boot_pkg::dec_instr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    // falling edge, new random hold, start back to low
    task automatic next_cycle();
        @(negedge clk);
        hold_prev = hold;
        // a held cycle never produces a record
        if (hold_prev) begin
            check_level("dec_valid", dec_valid, 1'b0);
        end
        start = 1'b0;
        hold = ($urandom % 100) < 30;
    endtask

    // one start, full load, full fetch
    task automatic run_once(input bit inject, input bit keep);
        int gap;
        int inj_at;
        int n_load;
        int n_rec;
        int waited;
        gap = $urandom % 8;
        inj_at = 5 + ($urandom % 75);
        // run_done from the previous run holds until start
        for (int i = 0; i < gap; i++) begin
            check_level("run_done", run_done, !keep);
            next_cycle();
        end
        start = 1'b1;
        next_cycle();
        check_level("run_done", run_done, 1'b0);
        n_load = 0;
        while (loading) begin
            n_load++;
            check_level("dec_valid", dec_valid, 1'b0);
            check_level("load_done", load_done, 1'b0);
            if (n_load > boot_pkg::prog_len) begin
                fail_now("loading stayed high past the end of the image");
            end
            // stray start in the middle of the load
            if (inject && n_load == inj_at) begin
                start = 1'b1;
            end
            next_cycle();
        end
        if (n_load != boot_pkg::prog_len) begin
            fail_now($sformatf("ERR loading cycles got %h expected %h",
                               n_load, boot_pkg::prog_len));
        end
        check_level("load_done", load_done, 1'b1);
        next_cycle();
        check_level("load_done", load_done, 1'b0);
        n_rec = 0;
        waited = 0;
        while (n_rec < boot_pkg::prog_len) begin
            check_level("run_done", run_done, 1'b0);
            if (dec_valid) begin
                // idx inside the record catches skips and repeats
                if (keep) begin
                    check_record("dec", dec, exp_recs[n_rec]);
                    first_run[n_rec] = dec;
                end else begin
                    // second run must reproduce the first one exactly
                    check_record("dec vs first run", dec, first_run[n_rec]);
                end
                n_rec++;
            end
            waited++;
            if (waited > 4 * boot_pkg::prog_len) begin
                fail_now("records stopped arriving before the end of the image");
            end
            next_cycle();
        end
        // sticky done, nothing more from fetch
        for (int i = 0; i < 6; i++) begin
            check_level("run_done", run_done, 1'b1);
            check_level("dec_valid", dec_valid, 1'b0);
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(32'h42e75f39));
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        hold = 1'b0;
        hold_prev = 1'b0;
        build_expected();
        // 8 rising edges in reset
        repeat (8) @(negedge clk);
        check_level("loading", loading, 1'b0);
        check_level("load_done", load_done, 1'b0);
        check_level("dec_valid", dec_valid, 1'b0);
        check_level("run_done", run_done, 1'b0);
        reset = 1'b0;
        // run one with a stray start, run two must match it
        run_once(1'b1, 1'b1);
        run_once(1'b0, 1'b0);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
